// File: files.f
tomasulo_pkg.sv
int_alu.sv
mult_pipe.sv
div_unit.sv
ls_mem.sv
cdb_issue.sv
exec_cluster_top.sv
tb_exec_cluster.sv

// File: Makefile
# Verilator build for the execution cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_cluster
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_exec_cluster.sv
`timescale 1ns/100ps

module tb_exec_cluster;

   localparam int MULT_LAT     = 4;
   localparam int MEM_WORDS    = 64;
   localparam int DIV_LAT      = tomasulo_pkg::DIV_LAT;
   localparam int HORIZON      = tomasulo_pkg::SLOT_DEPTH + 1;
   localparam int N_OPS        = 400;
   localparam int CLK_PERIOD   = 20;
   localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
   localparam int WATCHDOG_NS  = (N_OPS * (DIV_LAT + 4) + 10) * CLK_PERIOD;
   localparam logic [31:0] SEED = 32'h7a99a01e;

   // what the CDB should show in a given cycle
   localparam int K_NONE = 0;
   localparam int K_VAL  = 1;
   localparam int K_BR   = 2;
   localparam int K_ST   = 3;

   logic                  clk;
   logic                  rst_n;
   logic                  int_ready;
   tomasulo_pkg::int_op_t int_op;
   tomasulo_pkg::word_t   int_rs;
   tomasulo_pkg::word_t   int_rt;
   tomasulo_pkg::tag_t    int_tag;
   logic                  mult_ready;
   tomasulo_pkg::word_t   mult_rs;
   tomasulo_pkg::word_t   mult_rt;
   tomasulo_pkg::tag_t    mult_tag;
   logic                  div_ready;
   tomasulo_pkg::word_t   div_rs;
   tomasulo_pkg::word_t   div_rt;
   tomasulo_pkg::tag_t    div_tag;
   logic                  ls_ready;
   logic                  ls_store;
   tomasulo_pkg::word_t   ls_addr;
   tomasulo_pkg::word_t   ls_data;
   tomasulo_pkg::tag_t    ls_tag;
   logic                  int_done;
   logic                  mult_done;
   logic                  div_done;
   logic                  ls_done;
   logic                  cdb_valid;
   tomasulo_pkg::word_t   cdb_data;
   tomasulo_pkg::tag_t    cdb_tag;
   logic                  cdb_branch;
   logic                  cdb_branch_taken;
   logic                  int_carry;
   logic                  int_overflow;

   // reference model where entry i is the CDB i cycles from now
   int                    slot_kind  [HORIZON];
   tomasulo_pkg::word_t   slot_data  [HORIZON];
   tomasulo_pkg::tag_t    slot_tag   [HORIZON];
   logic                  slot_taken [HORIZON];
   logic                  slot_carry [HORIZON];
   logic                  slot_ovf   [HORIZON];
   logic                  slot_int   [HORIZON];
   tomasulo_pkg::word_t   ref_mem    [MEM_WORDS];
   logic [31:0]           lfsr;
   tomasulo_pkg::tag_t    tag_cnt;
   logic                  prio_ls;
   int                    div_wait;
   int                    issued;
   int                    accepted;
   logic                  int_acc;
   logic                  mult_acc;
   logic                  div_acc;
   logic                  ls_acc;

   exec_cluster_top #(.MULT_LAT(MULT_LAT), .MEM_WORDS(MEM_WORDS)) dut0 (
      .clk              (clk),
      .rst_n            (rst_n),
      .int_ready        (int_ready),
      .int_op           (int_op),
      .int_rs           (int_rs),
      .int_rt           (int_rt),
      .int_tag          (int_tag),
      .mult_ready       (mult_ready),
      .mult_rs          (mult_rs),
      .mult_rt          (mult_rt),
      .mult_tag         (mult_tag),
      .div_ready        (div_ready),
      .div_rs           (div_rs),
      .div_rt           (div_rt),
      .div_tag          (div_tag),
      .ls_ready         (ls_ready),
      .ls_store         (ls_store),
      .ls_addr          (ls_addr),
      .ls_data          (ls_data),
      .ls_tag           (ls_tag),
      .int_done         (int_done),
      .mult_done        (mult_done),
      .div_done         (div_done),
      .ls_done          (ls_done),
      .cdb_valid        (cdb_valid),
      .cdb_data         (cdb_data),
      .cdb_tag          (cdb_tag),
      .cdb_branch       (cdb_branch),
      .cdb_branch_taken (cdb_branch_taken),
      .int_carry        (int_carry),
      .int_overflow     (int_overflow)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] rnd(input int nbits);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < nbits; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic tomasulo_pkg::tag_t next_tag();
      tomasulo_pkg::tag_t t;
      t       = tag_cnt;
      tag_cnt = tag_cnt + 6'd1;
      return t;
   endfunction

   function automatic logic slots_idle();
      logic idle;
      idle = 1'b1;
      for (int i = 0; i < HORIZON; i++) begin
         if (slot_kind[i] != K_NONE) begin
            idle = 1'b0;
         end
      end
      return idle;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "%s", why);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
         $display("Test failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // integer semantics straight from the opcode definitions
   task automatic compute_int(input tomasulo_pkg::int_op_t op, input tomasulo_pkg::word_t a,
                              input tomasulo_pkg::word_t b, output tomasulo_pkg::word_t res,
                              output logic cy, output logic ov, output logic tk);
      logic [32:0] wide;
      res  = '0;
      cy   = 1'b0;
      ov   = 1'b0;
      tk   = 1'b0;
      wide = '0;
      case (op)
         tomasulo_pkg::OP_ADD: begin
            wide = {1'b0, a} + {1'b0, b};
            res  = wide[31:0];
            cy   = wide[32];
            ov   = (a[31] == b[31]) && (res[31] != a[31]);
         end
         tomasulo_pkg::OP_SUB: begin
            res = a - b;
            // carry set when no borrow
            cy  = (a >= b);
            ov  = (a[31] != b[31]) && (res[31] != a[31]);
         end
         tomasulo_pkg::OP_AND: res = a & b;
         tomasulo_pkg::OP_OR:  res = a | b;
         tomasulo_pkg::OP_XOR: res = a ^ b;
         tomasulo_pkg::OP_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         tomasulo_pkg::OP_BEQ: tk = (a == b);
         tomasulo_pkg::OP_BNE: tk = (a != b);
         default: res = '0;
      endcase
   endtask

   task automatic file_result(input int at, input int kind, input tomasulo_pkg::word_t data,
                              input tomasulo_pkg::tag_t tag, input logic taken,
                              input logic cy, input logic ov, input logic from_int);
      if (slot_kind[at] != K_NONE) begin
         abort_run("two operations were accepted for the same CDB cycle");
      end
      slot_kind[at]  = kind;
      slot_data[at]  = data;
      slot_tag[at]   = tag;
      slot_taken[at] = taken;
      slot_carry[at] = cy;
      slot_ovf[at]   = ov;
      slot_int[at]   = from_int;
   endtask

   task automatic shift_slots();
      for (int i = 0; i < HORIZON - 1; i++) begin
         slot_kind[i]  = slot_kind[i+1];
         slot_data[i]  = slot_data[i+1];
         slot_tag[i]   = slot_tag[i+1];
         slot_taken[i] = slot_taken[i+1];
         slot_carry[i] = slot_carry[i+1];
         slot_ovf[i]   = slot_ovf[i+1];
         slot_int[i]   = slot_int[i+1];
      end
      slot_kind[HORIZON-1]  = K_NONE;
      slot_data[HORIZON-1]  = '0;
      slot_tag[HORIZON-1]   = '0;
      slot_taken[HORIZON-1] = 1'b0;
      slot_carry[HORIZON-1] = 1'b0;
      slot_ovf[HORIZON-1]   = 1'b0;
      slot_int[HORIZON-1]   = 1'b0;
   endtask

   task automatic check_cdb();
      logic exp_valid;
      logic exp_branch;
      exp_valid  = (slot_kind[0] == K_VAL);
      exp_branch = (slot_kind[0] == K_BR);
      check_value("cdb_valid", {31'd0, cdb_valid}, {31'd0, exp_valid});
      check_value("cdb_branch", {31'd0, cdb_branch}, {31'd0, exp_branch});
      check_value("cdb_branch_taken", {31'd0, cdb_branch_taken}, {31'd0, slot_taken[0]});
      if (exp_valid) begin
         check_value("cdb_data", cdb_data, slot_data[0]);
      end
      if (exp_valid || exp_branch) begin
         check_value("cdb_tag", {26'd0, cdb_tag}, {26'd0, slot_tag[0]});
      end
      if (slot_int[0]) begin
         check_value("int_carry", {31'd0, int_carry}, {31'd0, slot_carry[0]});
         check_value("int_overflow", {31'd0, int_overflow}, {31'd0, slot_ovf[0]});
      end
   endtask

   // new operations only once the previous one is gone
   task automatic drive_queues();
      logic [31:0] pick;
      if (int_acc) begin
         int_ready = 1'b0;
         int_acc   = 1'b0;
      end
      if (!int_ready && issued < N_OPS && rnd(2) != 32'd0) begin
         int_ready = 1'b1;
         int_op    = 4'(rnd(3));
         int_rs    = rnd(32);
         pick      = rnd(2);
         // equal operands now and then so branches go both ways
         int_rt    = (pick == 32'd0) ? int_rs : rnd(32);
         int_tag   = next_tag();
         issued++;
      end
      if (mult_acc) begin
         mult_ready = 1'b0;
         mult_acc   = 1'b0;
      end
      if (!mult_ready && issued < N_OPS && rnd(2) != 32'd0) begin
         mult_ready = 1'b1;
         mult_rs    = rnd(32);
         mult_rt    = rnd(32);
         mult_tag   = next_tag();
         issued++;
      end
      if (div_acc) begin
         div_ready = 1'b0;
         div_acc   = 1'b0;
      end
      if (!div_ready && issued < N_OPS && rnd(2) == 32'd0) begin
         div_ready = 1'b1;
         div_rs    = rnd(32);
         pick      = rnd(3);
         div_rt    = (pick == 32'd0) ? 32'd0 : rnd(12);
         div_tag   = next_tag();
         issued++;
      end
      if (ls_acc) begin
         ls_ready = 1'b0;
         ls_acc   = 1'b0;
      end
      if (!ls_ready && issued < N_OPS && rnd(2) != 32'd0) begin
         ls_ready = 1'b1;
         ls_store = 1'(rnd(1));
         // small window of words so loads hit earlier stores
         ls_addr  = {26'd0, 4'(rnd(4)), 2'b00};
         ls_data  = rnd(32);
         ls_tag   = next_tag();
         issued++;
      end
   endtask

   task automatic check_cycle();
      logic                free0;
      logic                exp_int;
      logic                exp_ls;
      logic                exp_mult;
      logic                exp_div;
      logic                is_br;
      logic                cy;
      logic                ov;
      logic                tk;
      tomasulo_pkg::word_t res;
      int                  idx;
      check_cdb();
      free0    = (slot_kind[1] == K_NONE);
      exp_int  = int_ready && free0 && (!ls_ready || !prio_ls);
      exp_ls   = ls_ready && free0 && (!int_ready || prio_ls);
      exp_mult = mult_ready && (slot_kind[MULT_LAT] == K_NONE);
      exp_div  = div_ready && (div_wait == 0) && (slot_kind[DIV_LAT] == K_NONE);
      check_value("int_done", {31'd0, int_done}, {31'd0, exp_int});
      check_value("ls_done", {31'd0, ls_done}, {31'd0, exp_ls});
      check_value("mult_done", {31'd0, mult_done}, {31'd0, exp_mult});
      check_value("div_done", {31'd0, div_done}, {31'd0, exp_div});
      if (exp_int) begin
         compute_int(int_op, int_rs, int_rt, res, cy, ov, tk);
         is_br = (int_op == tomasulo_pkg::OP_BEQ) || (int_op == tomasulo_pkg::OP_BNE);
         file_result(1, is_br ? K_BR : K_VAL, res, int_tag, tk, cy, ov, 1'b1);
         int_acc = 1'b1;
         accepted++;
      end
      if (exp_ls) begin
         idx = int'(ls_addr[31:2]) % MEM_WORDS;
         if (ls_store) begin
            ref_mem[idx] = ls_data;
            file_result(1, K_ST, '0, ls_tag, 1'b0, 1'b0, 1'b0, 1'b0);
         end else begin
            file_result(1, K_VAL, ref_mem[idx], ls_tag, 1'b0, 1'b0, 1'b0, 1'b0);
         end
         ls_acc = 1'b1;
         accepted++;
      end
      if (exp_mult) begin
         file_result(MULT_LAT, K_VAL, mult_rs * mult_rt, mult_tag, 1'b0, 1'b0, 1'b0, 1'b0);
         mult_acc = 1'b1;
         accepted++;
      end
      if (exp_div) begin
         res = (div_rt == 32'd0) ? 32'hffff_ffff : div_rs / div_rt;
         file_result(DIV_LAT, K_VAL, res, div_tag, 1'b0, 1'b0, 1'b0, 1'b0);
         // divider stays busy through its result cycle
         div_wait = DIV_LAT;
         div_acc  = 1'b1;
         accepted++;
      end else if (div_wait > 0) begin
         div_wait--;
      end
      if (int_ready && ls_ready && free0) begin
         prio_ls = !prio_ls;
      end
      shift_slots();
   endtask

   initial begin
      #(WATCHDOG_NS);
      abort_run("watchdog expired before all operations completed");
   end

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      int_ready  = 1'b0;
      int_op     = '0;
      int_rs     = '0;
      int_rt     = '0;
      int_tag    = '0;
      mult_ready = 1'b0;
      mult_rs    = '0;
      mult_rt    = '0;
      mult_tag   = '0;
      div_ready  = 1'b0;
      div_rs     = '0;
      div_rt     = '0;
      div_tag    = '0;
      ls_ready   = 1'b0;
      ls_store   = 1'b0;
      ls_addr    = '0;
      ls_data    = '0;
      ls_tag     = '0;
      lfsr       = SEED;
      tag_cnt    = '0;
      prio_ls    = 1'b0;
      div_wait   = 0;
      issued     = 0;
      accepted   = 0;
      int_acc    = 1'b0;
      mult_acc   = 1'b0;
      div_acc    = 1'b0;
      ls_acc     = 1'b0;
      for (int i = 0; i < HORIZON; i++) begin
         slot_kind[i]  = K_NONE;
         slot_data[i]  = '0;
         slot_tag[i]   = '0;
         slot_taken[i] = 1'b0;
         slot_carry[i] = 1'b0;
         slot_ovf[i]   = 1'b0;
         slot_int[i]   = 1'b0;
      end
      for (int i = 0; i < MEM_WORDS; i++) begin
         ref_mem[i] = '0;
      end
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      while (accepted < N_OPS || !slots_idle()) begin
         drive_queues();
         #(SAMPLE_DELAY);
         check_cycle();
         @(negedge clk);
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

// File: exec_cluster_top.sv
`timescale 1ns/100ps

module exec_cluster_top #(
   parameter int MULT_LAT  = 4,
   parameter int MEM_WORDS = 64
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  int_ready,
   input  tomasulo_pkg::int_op_t int_op,
   input  tomasulo_pkg::word_t   int_rs,
   input  tomasulo_pkg::word_t   int_rt,
   input  tomasulo_pkg::tag_t    int_tag,
   input  logic                  mult_ready,
   input  tomasulo_pkg::word_t   mult_rs,
   input  tomasulo_pkg::word_t   mult_rt,
   input  tomasulo_pkg::tag_t    mult_tag,
   input  logic                  div_ready,
   input  tomasulo_pkg::word_t   div_rs,
   input  tomasulo_pkg::word_t   div_rt,
   input  tomasulo_pkg::tag_t    div_tag,
   input  logic                  ls_ready,
   input  logic                  ls_store,
   input  tomasulo_pkg::word_t   ls_addr,
   input  tomasulo_pkg::word_t   ls_data,
   input  tomasulo_pkg::tag_t    ls_tag,
   output logic                  int_done,
   output logic                  mult_done,
   output logic                  div_done,
   output logic                  ls_done,
   output logic                  cdb_valid,
   output tomasulo_pkg::word_t   cdb_data,
   output tomasulo_pkg::tag_t    cdb_tag,
   output logic                  cdb_branch,
   output logic                  cdb_branch_taken,
   output logic                  int_carry,
   output logic                  int_overflow
);

   tomasulo_pkg::word_t int_result;
   tomasulo_pkg::tag_t  int_res_tag;
   logic                int_branch;
   logic                int_taken;
   tomasulo_pkg::word_t mult_result;
   tomasulo_pkg::tag_t  mult_res_tag;
   logic                div_busy;
   tomasulo_pkg::word_t div_result;
   tomasulo_pkg::tag_t  div_res_tag;
   tomasulo_pkg::word_t ls_result;
   tomasulo_pkg::tag_t  ls_res_tag;

   cdb_issue #(.MULT_LAT(MULT_LAT)) issue0 (
      .clk              (clk),
      .rst_n            (rst_n),
      .int_ready        (int_ready),
      .mult_ready       (mult_ready),
      .div_ready        (div_ready),
      .ls_ready         (ls_ready),
      .ls_store         (ls_store),
      .div_busy         (div_busy),
      .int_result       (int_result),
      .int_res_tag      (int_res_tag),
      .int_branch       (int_branch),
      .int_taken        (int_taken),
      .mult_result      (mult_result),
      .mult_res_tag     (mult_res_tag),
      .div_result       (div_result),
      .div_res_tag      (div_res_tag),
      .ls_result        (ls_result),
      .ls_res_tag       (ls_res_tag),
      .int_done         (int_done),
      .mult_done        (mult_done),
      .div_done         (div_done),
      .ls_done          (ls_done),
      .cdb_valid        (cdb_valid),
      .cdb_data         (cdb_data),
      .cdb_tag          (cdb_tag),
      .cdb_branch       (cdb_branch),
      .cdb_branch_taken (cdb_branch_taken)
   );

   // units start on the done pulse of their queue
   int_alu alu0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (int_done),
      .op       (int_op),
      .rs       (int_rs),
      .rt       (int_rt),
      .tag      (int_tag),
      .result   (int_result),
      .res_tag  (int_res_tag),
      .carry    (int_carry),
      .overflow (int_overflow),
      .branch   (int_branch),
      .taken    (int_taken)
   );

   mult_pipe #(.MULT_LAT(MULT_LAT)) mult0 (
      .clk     (clk),
      .start   (mult_done),
      .rs      (mult_rs),
      .rt      (mult_rt),
      .tag     (mult_tag),
      .result  (mult_result),
      .res_tag (mult_res_tag)
   );

   div_unit div0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (div_done),
      .rs      (div_rs),
      .rt      (div_rt),
      .tag     (div_tag),
      .busy    (div_busy),
      .result  (div_result),
      .res_tag (div_res_tag)
   );

   ls_mem #(.MEM_WORDS(MEM_WORDS)) mem0 (
      .clk     (clk),
      .start   (ls_done),
      .store   (ls_store),
      .addr    (ls_addr),
      .wdata   (ls_data),
      .tag     (ls_tag),
      .rdata   (ls_result),
      .res_tag (ls_res_tag)
   );

endmodule

// File: cdb_issue.sv
`timescale 1ns/100ps

module cdb_issue #(
   parameter int MULT_LAT = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                int_ready,
   input  logic                mult_ready,
   input  logic                div_ready,
   input  logic                ls_ready,
   input  logic                ls_store,
   input  logic                div_busy,
   input  tomasulo_pkg::word_t int_result,
   input  tomasulo_pkg::tag_t  int_res_tag,
   input  logic                int_branch,
   input  logic                int_taken,
   input  tomasulo_pkg::word_t mult_result,
   input  tomasulo_pkg::tag_t  mult_res_tag,
   input  tomasulo_pkg::word_t div_result,
   input  tomasulo_pkg::tag_t  div_res_tag,
   input  tomasulo_pkg::word_t ls_result,
   input  tomasulo_pkg::tag_t  ls_res_tag,
   output logic                int_done,
   output logic                mult_done,
   output logic                div_done,
   output logic                ls_done,
   output logic                cdb_valid,
   output tomasulo_pkg::word_t cdb_data,
   output tomasulo_pkg::tag_t  cdb_tag,
   output logic                cdb_branch,
   output logic                cdb_branch_taken
);

   localparam int DEPTH  = tomasulo_pkg::SLOT_DEPTH;
   localparam int U_INT  = 0;
   localparam int U_MULT = 1;
   localparam int U_DIV  = 2;
   localparam int U_LS   = 3;

   // one-hot owner per future slot, entry k is the cycle k+1 ahead
   logic [DEPTH-1:0][3:0] own_q;
   logic [DEPTH-1:0][3:0] own_nxt;
   logic [DEPTH-1:0]      resv;
   logic [3:0]            cur_own;
   logic                  cur_store;
   logic                  prio_ls_q;
   logic                  slot0_free;
   logic                  contend;

   // reservation vector is the or of the owner records
   always_comb begin
      for (int k = 0; k < DEPTH; k++) begin
         resv[k] = |own_q[k];
      end
   end

   assign slot0_free = ~resv[0];
   assign contend    = int_ready & ls_ready & slot0_free;

   assign int_done  = int_ready & slot0_free & (~ls_ready | ~prio_ls_q);
   assign ls_done   = ls_ready & slot0_free & (~int_ready | prio_ls_q);
   assign mult_done = mult_ready & ~resv[MULT_LAT-1];
   assign div_done  = div_ready & ~div_busy & ~resv[tomasulo_pkg::DIV_LAT-1];

   always_comb begin
      own_nxt = own_q;
      own_nxt[0][U_INT] |= int_done;
      own_nxt[0][U_LS]  |= ls_done;
      own_nxt[MULT_LAT-1][U_MULT] |= mult_done;
      own_nxt[tomasulo_pkg::DIV_LAT-1][U_DIV] |= div_done;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         own_q     <= '0;
         cur_own   <= '0;
         cur_store <= 1'b0;
         prio_ls_q <= 1'b0;
      end else begin
         own_q     <= {4'b0000, own_nxt[DEPTH-1:1]};
         cur_own   <= own_nxt[0];
         cur_store <= ls_done & ls_store;
         // alternate int and ls after each tie
         prio_ls_q <= prio_ls_q ^ contend;
      end
   end

   always_comb begin
      cdb_valid        = 1'b0;
      cdb_data         = '0;
      cdb_tag          = '0;
      cdb_branch       = 1'b0;
      cdb_branch_taken = 1'b0;
      if (cur_own[U_INT]) begin
         cdb_data         = int_result;
         cdb_tag          = int_res_tag;
         cdb_valid        = ~int_branch;
         cdb_branch       = int_branch;
         cdb_branch_taken = int_taken;
      end else if (cur_own[U_MULT]) begin
         cdb_data  = mult_result;
         cdb_tag   = mult_res_tag;
         cdb_valid = 1'b1;
      end else if (cur_own[U_DIV]) begin
         cdb_data  = div_result;
         cdb_tag   = div_res_tag;
         cdb_valid = 1'b1;
      end else if (cur_own[U_LS]) begin
         // store keeps its slot but stays off the bus
         cdb_data  = ls_result;
         cdb_tag   = ls_res_tag;
         cdb_valid = ~cur_store;
      end
   end

   a_one_owner: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(cur_own));

endmodule

// File: ls_mem.sv
`timescale 1ns/100ps

module ls_mem #(
   parameter int MEM_WORDS = 64
) (
   input  logic                clk,
   input  logic                start,
   input  logic                store,
   input  tomasulo_pkg::word_t addr,
   input  tomasulo_pkg::word_t wdata,
   input  tomasulo_pkg::tag_t  tag,
   output tomasulo_pkg::word_t rdata,
   output tomasulo_pkg::tag_t  res_tag
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   tomasulo_pkg::word_t mem [MEM_WORDS];
   logic [IDX_W-1:0]    idx;

   // byte address to word index, wraps at MEM_WORDS
   assign idx = addr[IDX_W+1:2];

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         if (store) begin
            mem[idx] <= wdata;
         end else begin
            rdata   <= mem[idx];
            res_tag <= tag;
         end
      end
   end

   // word accesses only
   a_aligned: assert property (@(posedge clk) start |-> addr[1:0] == 2'b00);

endmodule

// File: div_unit.sv
`timescale 1ns/100ps

module div_unit (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                start,
   input  tomasulo_pkg::word_t rs,
   input  tomasulo_pkg::word_t rt,
   input  tomasulo_pkg::tag_t  tag,
   output logic                busy,
   output tomasulo_pkg::word_t result,
   output tomasulo_pkg::tag_t  res_tag
);

   tomasulo_pkg::div_state_t state_q;
   logic [2:0]               iter_q;
   tomasulo_pkg::word_t      quo_q;
   tomasulo_pkg::word_t      rem_q;
   tomasulo_pkg::word_t      dvs_q;
   tomasulo_pkg::tag_t       tag_q;
   tomasulo_pkg::word_t      quo_d;
   tomasulo_pkg::word_t      rem_d;
   logic [32:0]              trial;
   logic [32:0]              diff;

   // four restoring steps per cycle
   always_comb begin
      quo_d = quo_q;
      rem_d = rem_q;
      trial = '0;
      diff  = '0;
      for (int i = 0; i < 4; i++) begin
         trial = {rem_d, quo_d[31]};
         diff  = trial - {1'b0, dvs_q};
         // negative difference restores the remainder
         quo_d = {quo_d[30:0], ~diff[32]};
         rem_d = diff[32] ? trial[31:0] : diff[31:0];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= tomasulo_pkg::DIV_IDLE;
         iter_q  <= '0;
      end else begin
         case (state_q)
            tomasulo_pkg::DIV_IDLE: begin
               if (start) begin
                  state_q <= tomasulo_pkg::DIV_RUN;
                  iter_q  <= '0;
               end
            end
            tomasulo_pkg::DIV_RUN: begin
               iter_q <= iter_q + 3'd1;
               if (iter_q == 3'd7) begin
                  state_q <= tomasulo_pkg::DIV_DONE;
               end
            end
            default: state_q <= tomasulo_pkg::DIV_IDLE;
         endcase
      end
   end

   // zero divisor falls out as all ones
   always_ff @(posedge clk) begin
      if (state_q == tomasulo_pkg::DIV_IDLE && start) begin
         quo_q <= rs;
         rem_q <= '0;
         dvs_q <= rt;
         tag_q <= tag;
      end else if (state_q == tomasulo_pkg::DIV_RUN) begin
         quo_q <= quo_d;
         rem_q <= rem_d;
      end
   end

   assign busy    = (state_q != tomasulo_pkg::DIV_IDLE);
   assign result  = quo_q;
   assign res_tag = tag_q;

   // issue unit must hold divides while busy
   a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

// File: mult_pipe.sv
`timescale 1ns/100ps

module mult_pipe #(
   parameter int MULT_LAT = 4
) (
   input  logic                clk,
   input  logic                start,
   input  tomasulo_pkg::word_t rs,
   input  tomasulo_pkg::word_t rt,
   input  tomasulo_pkg::tag_t  tag,
   output tomasulo_pkg::word_t result,
   output tomasulo_pkg::tag_t  res_tag
);

   tomasulo_pkg::word_t prod_q [MULT_LAT];
   tomasulo_pkg::tag_t  tag_q  [MULT_LAT];
   tomasulo_pkg::word_t prod_d;

   // low half of the unsigned product
   assign prod_d = rs * rt;

   // first stage only loads on an accepted operation
   always_ff @(posedge clk) begin
      if (start) begin
         prod_q[0] <= prod_d;
         tag_q[0]  <= tag;
      end
   end

   // remaining stages shift every cycle so products overlap
   always_ff @(posedge clk) begin
      for (int i = 1; i < MULT_LAT; i++) begin
         prod_q[i] <= prod_q[i-1];
         tag_q[i]  <= tag_q[i-1];
      end
   end

   assign result  = prod_q[MULT_LAT-1];
   assign res_tag = tag_q[MULT_LAT-1];

endmodule

// File: int_alu.sv
`timescale 1ns/100ps

module int_alu (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  tomasulo_pkg::int_op_t op,
   input  tomasulo_pkg::word_t   rs,
   input  tomasulo_pkg::word_t   rt,
   input  tomasulo_pkg::tag_t    tag,
   output tomasulo_pkg::word_t   result,
   output tomasulo_pkg::tag_t    res_tag,
   output logic                  carry,
   output logic                  overflow,
   output logic                  branch,
   output logic                  taken
);

   logic                is_sub;
   logic                is_arith;
   logic                is_br;
   tomasulo_pkg::word_t rt_eff;
   logic [32:0]         sum;
   tomasulo_pkg::word_t res_d;

   assign is_sub   = (op == tomasulo_pkg::OP_SUB);
   assign is_arith = is_sub | (op == tomasulo_pkg::OP_ADD);
   assign is_br    = (op == tomasulo_pkg::OP_BEQ) | (op == tomasulo_pkg::OP_BNE);

   // subtract as rs + ~rt + 1
   assign rt_eff = is_sub ? ~rt : rt;
   assign sum    = {1'b0, rs} + {1'b0, rt_eff} + {32'd0, is_sub};

   always_comb begin
      case (op)
         tomasulo_pkg::OP_ADD, tomasulo_pkg::OP_SUB: res_d = sum[31:0];
         tomasulo_pkg::OP_AND: res_d = rs & rt;
         tomasulo_pkg::OP_OR:  res_d = rs | rt;
         tomasulo_pkg::OP_XOR: res_d = rs ^ rt;
         tomasulo_pkg::OP_SLT: res_d = 32'($signed(rs) < $signed(rt));
         default:              res_d = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         carry    <= 1'b0;
         overflow <= 1'b0;
         branch   <= 1'b0;
         taken    <= 1'b0;
      end else if (start) begin
         carry    <= is_arith & sum[32];
         // operands of equal sign, result of the other
         overflow <= is_arith & (rs[31] == rt_eff[31]) & (sum[31] != rs[31]);
         branch   <= is_br;
         taken    <= is_br & ((op == tomasulo_pkg::OP_BNE) ? (rs != rt) : (rs == rt));
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         result  <= res_d;
         res_tag <= tag;
      end
   end

endmodule

// File: tomasulo_pkg.sv
package tomasulo_pkg;

   typedef logic [31:0] word_t;
   typedef logic [5:0]  tag_t;
   typedef logic [3:0]  int_op_t;

   // integer opcodes
   localparam int_op_t OP_ADD = 4'h0;
   localparam int_op_t OP_SUB = 4'h1;
   localparam int_op_t OP_AND = 4'h2;
   localparam int_op_t OP_OR  = 4'h3;
   localparam int_op_t OP_XOR = 4'h4;
   localparam int_op_t OP_SLT = 4'h5;
   localparam int_op_t OP_BEQ = 4'h6;
   localparam int_op_t OP_BNE = 4'h7;

   // 8 radix-16 iterations plus the result cycle
   localparam int DIV_LAT = 9;

   // longest latency sets the reservation depth
   localparam int SLOT_DEPTH = DIV_LAT;

   typedef enum logic [1:0] {
      DIV_IDLE,
      DIV_RUN,
      DIV_DONE
   } div_state_t;

endpackage
